/* logic/mul_defines.svh */
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// Width macros for the multiply unit
// Both are fixed by the ISA and shared by every stage

// Operand and result width
// Operands split into two halves of MUL_XLEN/2 bits
// Product before word selection is twice this wide
`define MUL_XLEN 32

// Destination register address width
// 32 architectural registers
`define MUL_RD_W 5

// Low and high words of the full product are both MUL_XLEN wide
// Writeback data is one of those words

`endif

/* logic/mul_pkg.sv */
`include "mul_defines.svh"

package mul_pkg;

    // Operation codes from the decoder
    // Code 2'd3 is unused
    typedef enum logic [1:0] {
        MUL_W   = 2'd0,
        MULH_W  = 2'd1,
        MULH_WU = 2'd2
    } mul_op_t;

    // Issued request, output of the issue register
    typedef struct packed {
        // Valid strobe for this operation
        logic                  en;
        // Destination register, zero when idle
        logic [`MUL_RD_W-1:0]  rd;
        // 1 selects the high word
        logic                  sel;
        // 1 requests the signed high-word correction
        logic                  sign;
        // Raw operands
        logic [`MUL_XLEN-1:0]  src0;
        logic [`MUL_XLEN-1:0]  src1;
    } mul_req_t;

    // Stage 0 result, partial products plus correction
    typedef struct packed {
        logic                  en;
        logic [`MUL_RD_W-1:0]  rd;
        logic                  sel;
        // High half times high half
        logic [`MUL_XLEN-1:0]  hh;
        // High half of src0 times low half of src1
        logic [`MUL_XLEN-1:0]  hl;
        // Low half of src0 times high half of src1
        logic [`MUL_XLEN-1:0]  lh;
        // Low half times low half
        logic [`MUL_XLEN-1:0]  ll;
        // Added to the unsigned high word for mulh.w
        logic [`MUL_XLEN-1:0]  ad;
    } mul_mid_t;

    // Writeback word
    typedef struct packed {
        logic                  en;
        logic [`MUL_RD_W-1:0]  rd;
        logic [`MUL_XLEN-1:0]  data;
    } mul_wb_t;

endpackage

/* logic/mul_issue.sv */
`include "mul_defines.svh"

module mul_issue (
    input  logic                  clk,
    input  logic                  rst_n,
    // Operation strobe and fields from the decoder
    input  logic                  issue_en,
    input  mul_pkg::mul_op_t      issue_op,
    input  logic [`MUL_RD_W-1:0]  issue_rd,
    input  logic [`MUL_XLEN-1:0]  src0,
    input  logic [`MUL_XLEN-1:0]  src1,
    // Registered request into stage 0
    output mul_pkg::mul_req_t     req
);
    import mul_pkg::*;

    // Decoded controls
    logic     sel_dec;
    logic     sign_dec;
    mul_req_t req_d;

    // Op code to word select and sign handling
    always_comb begin
        case (issue_op)
            MUL_W: begin
                // Low word is the same for signed and unsigned
                sel_dec  = 1'b0;
                sign_dec = 1'b0;
            end
            MULH_W: begin
                // Signed high word needs the correction term
                sel_dec  = 1'b1;
                sign_dec = 1'b1;
            end
            MULH_WU: begin
                // Unsigned high word taken as is
                sel_dec  = 1'b1;
                sign_dec = 1'b0;
            end
            default: begin
                sel_dec  = 1'b0;
                sign_dec = 1'b0;
            end
        endcase
    end

    // Next request word
    always_comb begin
        req_d.en   = issue_en;
        // Idle slots carry no destination
        req_d.rd   = issue_en ? issue_rd : '0;
        req_d.sel  = sel_dec;
        req_d.sign = sign_dec;
        req_d.src0 = src0;
        req_d.src1 = src1;
    end

    // Issue register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req <= '0;
        end else begin
            req <= req_d;
        end
    end

    // Decoder must never hand over the spare op code
    a_issue_op_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_en |-> issue_op inside {MUL_W, MULH_W, MULH_WU}
    ) else $error("mul_issue: unused op code %0d issued", issue_op);

endmodule

/* logic/mul_partial.sv */
`include "mul_defines.svh"

module mul_partial (
    input  logic               clk,
    input  logic               rst_n,
    // Request from the issue register
    input  mul_pkg::mul_req_t  req,
    // Registered partial products
    output mul_pkg::mul_mid_t  mid
);
    import mul_pkg::*;

    // Operand half width
    localparam int unsigned HALF = `MUL_XLEN / 2;

    logic [`MUL_XLEN-1:0] a_hi;
    logic [`MUL_XLEN-1:0] a_lo;
    logic [`MUL_XLEN-1:0] b_hi;
    logic [`MUL_XLEN-1:0] b_lo;
    logic [`MUL_XLEN-1:0] corr;
    mul_mid_t             mid_d;

    // Zero-extended operand halves
    always_comb begin
        a_hi = {{HALF{1'b0}}, req.src0[`MUL_XLEN-1:HALF]};
        a_lo = {{HALF{1'b0}}, req.src0[HALF-1:0]};
        b_hi = {{HALF{1'b0}}, req.src1[`MUL_XLEN-1:HALF]};
        b_lo = {{HALF{1'b0}}, req.src1[HALF-1:0]};
    end

    // High-word correction for signed operands
    // Operands are multiplied as unsigned values
    // A negative operand x adds 2^32 * other to the product
    // so the unsigned high word is too large by the other operand
    always_comb begin
        corr = '0;
        if (req.sign) begin
            case ({req.src0[`MUL_XLEN-1], req.src1[`MUL_XLEN-1]})
                // Both negative, take off both operands
                2'b11:   corr = -(req.src0 + req.src1);
                // Only src0 negative
                2'b10:   corr = -req.src1;
                // Only src1 negative
                2'b01:   corr = -req.src0;
                default: corr = '0;
            endcase
        end
    end

    // Four 16x16 products, each fits in one word
    always_comb begin
        mid_d.en  = req.en;
        mid_d.rd  = req.rd;
        mid_d.sel = req.sel;
        mid_d.hh  = a_hi * b_hi;
        mid_d.hl  = a_hi * b_lo;
        mid_d.lh  = a_lo * b_hi;
        mid_d.ll  = a_lo * b_lo;
        mid_d.ad  = corr;
    end

    // Stage 0 register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mid <= '0;
        end else begin
            mid <= mid_d;
        end
    end

    // Unsigned ops must never pick up a correction
    a_no_corr_unsigned: assert property (
        @(posedge clk) disable iff (!rst_n)
        !req.sign |=> mid.ad == '0
    ) else $error("mul_partial: correction %h without sign", mid.ad);

endmodule

/* logic/mul_combine.sv */
`include "mul_defines.svh"

module mul_combine (
    input  logic               clk,
    input  logic               rst_n,
    // Partial products from stage 0
    input  mul_pkg::mul_mid_t  mid,
    // Selected result word, not masked
    output mul_pkg::mul_wb_t   res
);
    import mul_pkg::*;

    localparam int unsigned HALF = `MUL_XLEN / 2;

    // Middle products can carry into bit 32
    logic [`MUL_XLEN:0]     mid_sum;
    // Middle sum aligned to its weight
    logic [2*`MUL_XLEN-1:0] mid_wide;
    // Full unsigned product
    logic [2*`MUL_XLEN-1:0] full;
    logic [`MUL_XLEN-1:0]   word;
    mul_wb_t                res_d;

    // Sum of cross products
    always_comb begin
        mid_sum  = {1'b0, mid.hl} + {1'b0, mid.lh};
        mid_wide = {{(`MUL_XLEN-1){1'b0}}, mid_sum} << HALF;
        // hh and ll do not overlap, so they concatenate
        full     = {mid.hh, mid.ll} + mid_wide;
    end

    // Word pick
    always_comb begin
        if (mid.sel) begin
            // High word, signed fix added mod 2^32
            word = full[2*`MUL_XLEN-1:`MUL_XLEN] + mid.ad;
        end else begin
            word = full[`MUL_XLEN-1:0];
        end
    end

    always_comb begin
        res_d.en   = mid.en;
        res_d.rd   = mid.rd;
        res_d.data = word;
    end

    // Stage 1 register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res <= '0;
        end else begin
            res <= res_d;
        end
    end

endmodule

/* logic/mul_writeback.sv */
`include "mul_defines.svh"

module mul_writeback (
    input  logic              clk,
    input  logic              rst_n,
    // Result from stage 1
    input  mul_pkg::mul_wb_t  res,
    // Shared writeback bus, zero when idle
    output mul_pkg::mul_wb_t  wb
);
    import mul_pkg::*;

    mul_wb_t wb_d;

    // Idle slots drive all zeros so the bus can be OR-merged
    always_comb begin
        wb_d = res.en ? res : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb <= wb_d;
        end
    end

    // Idle bus carries nothing
    a_wb_idle_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !wb.en |-> (wb.rd == '0 && wb.data == '0)
    ) else $error("mul_writeback: idle bus rd=%h data=%h", wb.rd, wb.data);

endmodule

/* logic/mul_unit.sv */
`include "mul_defines.svh"

module mul_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    // Issue side, sampled together with issue_en
    input  logic                  issue_en,
    input  mul_pkg::mul_op_t      issue_op,
    input  logic [`MUL_RD_W-1:0]  issue_rd,
    input  logic [`MUL_XLEN-1:0]  src0,
    input  logic [`MUL_XLEN-1:0]  src1,
    // Writeback bus, four cycles after issue
    output mul_pkg::mul_wb_t      wb
);
    import mul_pkg::*;

    // Stage boundaries
    mul_req_t req;
    mul_mid_t mid;
    mul_wb_t  res;

    // Op decode and operand capture
    mul_issue i_issue (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue_en (issue_en),
        .issue_op (issue_op),
        .issue_rd (issue_rd),
        .src0     (src0),
        .src1     (src1),
        .req      (req)
    );

    // Partial products and correction
    mul_partial i_partial (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .mid   (mid)
    );

    // Summation and word select
    mul_combine i_combine (
        .clk   (clk),
        .rst_n (rst_n),
        .mid   (mid),
        .res   (res)
    );

    // Masked bus register
    mul_writeback i_writeback (
        .clk   (clk),
        .rst_n (rst_n),
        .res   (res),
        .wb    (wb)
    );

endmodule

/* testbench/tb_mul_unit.sv */
`include "mul_defines.svh"

module tb_mul_unit;
    timeunit 1ns;
    timeprecision 100ps;

    import mul_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    // Three ops times all 5x5 corner pairs
    localparam int CORNER_OPS   = 75;
    localparam int RANDOM_OPS   = 60;
    localparam int TOTAL_OPS    = CORNER_OPS + RANDOM_OPS;
    localparam int WATCH_CYCLES = TOTAL_OPS + RESET_CYCLES + 20;

    // Expected result, held until its writeback cycle
    typedef struct packed {
        mul_op_t                 op;
        logic [`MUL_RD_W-1:0]    rd;
        logic [2*`MUL_XLEN-1:0]  prod;
        logic [31:0]             due;
    } ref_entry_t;

    // DUT signals
    logic                  clk;
    logic                  rst_n;
    logic                  issue_en;
    mul_op_t               issue_op;
    logic [`MUL_RD_W-1:0]  issue_rd;
    logic [`MUL_XLEN-1:0]  src0;
    logic [`MUL_XLEN-1:0]  src1;
    mul_wb_t               wb;

    // Reference model state
    ref_entry_t            ref_q[$];
    ref_entry_t            new_entry;
    ref_entry_t            head;
    logic [31:0]           cyc;
    logic                  exp_en;
    logic [`MUL_RD_W-1:0]  exp_rd;
    logic [`MUL_XLEN-1:0]  exp_data;

    integer                seed;
    int                    ops_issued;
    int                    results_due;
    int                    err_value;
    int                    err_missing;
    int                    err_extra;

    mul_unit i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue_en (issue_en),
        .issue_op (issue_op),
        .issue_rd (issue_rd),
        .src0     (src0),
        .src1     (src1),
        .wb       (wb)
    );

    always begin
        #(CLK_PERIOD / 2);
        clk = ~clk;
    end

    // Full 64-bit product, signed only for mulh.w
    function automatic logic [2*`MUL_XLEN-1:0] product_of(input mul_op_t op,
                                                          input logic [`MUL_XLEN-1:0] a,
                                                          input logic [`MUL_XLEN-1:0] b);
        logic signed [2*`MUL_XLEN-1:0] sa;
        logic signed [2*`MUL_XLEN-1:0] sb;
        sa = {{`MUL_XLEN{a[`MUL_XLEN-1]}}, a};
        sb = {{`MUL_XLEN{b[`MUL_XLEN-1]}}, b};
        if (op == MULH_W) begin
            return sa * sb;
        end
        return {{`MUL_XLEN{1'b0}}, a} * {{`MUL_XLEN{1'b0}}, b};
    endfunction

    // mul.w keeps the low word, both mulh forms the high word
    function automatic logic [`MUL_XLEN-1:0] word_of(input mul_op_t op,
                                                     input logic [2*`MUL_XLEN-1:0] prod);
        if (op == MUL_W) begin
            return prod[`MUL_XLEN-1:0];
        end
        return prod[2*`MUL_XLEN-1:`MUL_XLEN];
    endfunction

    function automatic mul_op_t op_from_code(input logic [1:0] code);
        case (code)
            2'd0:    return MUL_W;
            2'd1:    return MULH_W;
            default: return MULH_WU;
        endcase
    endfunction

    // Zero, one, all ones, most negative, most positive
    function automatic logic [`MUL_XLEN-1:0] corner_value(input logic [2:0] k);
        case (k)
            3'd0:    return '0;
            3'd1:    return 32'h0000_0001;
            3'd2:    return 32'hffff_ffff;
            3'd3:    return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    // Random word, about one draw in four replaced by a corner
    function automatic logic [`MUL_XLEN-1:0] next_operand();
        logic [31:0] r;
        logic [2:0]  k;
        r = $random(seed);
        k = r[4:2] % 3'd5;
        if (r[1:0] == 2'b00) begin
            return corner_value(k);
        end
        r = $random(seed);
        return r;
    endfunction

    task automatic drive_op(input mul_op_t op, input logic [`MUL_RD_W-1:0] rd,
                            input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b);
        @(posedge clk);
        #10;
        issue_en   = 1'b1;
        issue_op   = op;
        issue_rd   = rd;
        src0       = a;
        src1       = b;
        ops_issued = ops_issued + 1;
    endtask

    // Idle slots still carry junk operands and destination
    task automatic hold_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
            issue_en = 1'b0;
            issue_op = MULH_W;
            issue_rd = 5'h1f;
            src0     = $random(seed);
            src1     = $random(seed);
        end
    endtask

    // Reference queue, one entry per sampled issue
    always @(posedge clk) begin
        if (!rst_n) begin
            cyc      <= '0;
            exp_en   <= 1'b0;
            exp_rd   <= '0;
            exp_data <= '0;
            ref_q.delete();
        end else begin
            if (issue_en) begin
                new_entry.op   = issue_op;
                new_entry.rd   = issue_rd;
                new_entry.prod = product_of(issue_op, src0, src1);
                // Four register stages to the bus
                new_entry.due  = cyc + 32'd4;
                ref_q.push_back(new_entry);
            end
            // Head is due on wb right after this edge
            if (ref_q.size() != 0 && ref_q[0].due == cyc + 32'd1) begin
                head        = ref_q.pop_front();
                exp_en      <= 1'b1;
                exp_rd      <= head.rd;
                exp_data    <= word_of(head.op, head.prod);
                results_due = results_due + 1;
            end else begin
                exp_en   <= 1'b0;
                exp_rd   <= '0;
                exp_data <= '0;
            end
            cyc <= cyc + 32'd1;
        end
    end

    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n) !exp_en |-> !wb.en)
        else begin
            err_extra = err_extra + 1;
            $display("Unexpected result on the writeback bus at %0t", $time);
        end

    a_no_missing: assert property (@(posedge clk) disable iff (!rst_n) exp_en |-> wb.en)
        else begin
            err_missing = err_missing + 1;
            $display("Expected result did not appear on the writeback bus at %0t", $time);
        end

    a_rd_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        (exp_en && wb.en) |-> wb.rd == exp_rd
    ) else begin
        err_value = err_value + 1;
        $display("FAILED wb.rd: expected %h, actual %h", $sampled(exp_rd), $sampled(wb.rd));
    end

    a_data_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        (exp_en && wb.en) |-> wb.data == exp_data
    ) else begin
        err_value = err_value + 1;
        $display("FAILED wb.data: expected %h, actual %h",
                 $sampled(exp_data), $sampled(wb.data));
    end

    // Idle bus must read as all zeros
    a_idle_clear: assert property (
        @(posedge clk) disable iff (!rst_n)
        !wb.en |-> (wb.rd == '0 && wb.data == '0)
    ) else begin
        err_value = err_value + 1;
        $display("FAILED wb idle: expected rd %h data %h, actual rd %h data %h",
                 5'h00, 32'h0, $sampled(wb.rd), $sampled(wb.data));
    end

    // Watchdog
    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCH_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [`MUL_RD_W-1:0] rd_ctr;
        logic [31:0]          r;
        logic [1:0]           code;
        int                   total;
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue_en    = 1'b0;
        issue_op    = MUL_W;
        issue_rd    = '0;
        src0        = '0;
        src1        = '0;
        seed        = 78345;
        ops_issued  = 0;
        results_due = 0;
        err_value   = 0;
        err_missing = 0;
        err_extra   = 0;
        rd_ctr      = 5'd1;

        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
        // Bus stays clear after reset
        hold_idle(3);

        // Every op over every corner pair, back to back
        for (int o = 0; o < 3; o++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    drive_op(op_from_code(o[1:0]), rd_ctr,
                             corner_value(i[2:0]), corner_value(j[2:0]));
                    rd_ctr = rd_ctr + 5'd1;
                end
            end
        end
        hold_idle(2);

        // Mixed ops and destinations, one per cycle
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r    = $random(seed);
            code = (r[1:0] == 2'd3) ? {1'b0, r[2]} : r[1:0];
            drive_op(op_from_code(code), r[12:8], next_operand(), next_operand());
        end

        // Drain the pipeline
        while (ref_q.size() != 0) begin
            hold_idle(1);
        end
        hold_idle(2);

        total = err_value + err_missing + err_extra;
        $display("Done: %0d issued, %0d due, %0d value errors, %0d missing, %0d unexpected",
                 ops_issued, results_due, err_value, err_missing, err_extra);
        if (total == 0 && results_due == ops_issued) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+logic
logic/mul_pkg.sv
logic/mul_issue.sv
logic/mul_partial.sv
logic/mul_combine.sv
logic/mul_writeback.sv
logic/mul_unit.sv
testbench/tb_mul_unit.sv

/* Makefile */
# Verilator build and run for the multiply unit

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_mul_unit
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
